// ==== verification/snes_map_vectors.txt ====
# name feat mapper(dec) saveram_mask rom_mask addr pa wr wdata outcome exp_addr exp_data
# hex except mapper and wr; exp_data is the read byte, exp_addr the memory address
hi_rom0      00 0 001FFF 3FFFFF C01234 00 0 00 MEM    001234 6E
hi_rom1      00 0 001FFF 3FFFFF 008765 00 0 00 MEM    008765 3F
hi_sram_wr   00 0 001FFF 3FFFFF 306010 00 1 A5 MEM    E00010 00
hi_sram_rd   00 0 001FFF 3FFFFF 306010 00 0 00 MEM    E00010 A5
hi_open      00 0 001FFF 3FFFFF 001000 00 0 00 OPEN   000000 FF
hi_rom_wr    00 0 001FFF 3FFFFF C01234 00 1 77 DROP   000000 00
hi_rom_chk   00 0 001FFF 3FFFFF C01234 00 0 00 MEM    001234 6E
lo_rom0      00 1 001FFF 3FFFFF 018000 00 0 00 MEM    008000 5A
lo_rom1      00 1 001FFF 3FFFFF 80FFEE 00 0 00 MEM    007FEE B4
lo_sram_wr   00 1 001FFF 3FFFFF 700123 00 1 3C MEM    E00123 00
lo_sram_rd   00 1 001FFF 3FFFFF 700123 00 0 00 MEM    E00123 3C
lo_hi_big    00 1 001FFF 3FFFFF 708123 00 0 00 MEM    380123 79
lo_hi_small  00 1 001FFF 1FFFFF 708456 00 0 00 MEM    E00456 0C
lo_hi_wr     00 1 001FFF 1FFFFF 708456 00 1 99 MEM    E00456 00
lo_hi_rd     00 1 001FFF 1FFFFF 708456 00 0 00 MEM    E00456 99
lo_rom_wr    00 1 001FFF 1FFFFF 018000 00 1 12 DROP   000000 00
lo_open      00 1 001FFF 1FFFFF 002100 00 0 00 OPEN   000000 FF
ex_rom_hi    00 2 001FFF 7FFFFF C05678 00 0 00 MEM    005678 22
ex_rom_lo    00 2 001FFF 7FFFFF 405678 00 0 00 MEM    405678 22
ex_sram_wr   00 2 001FFF 7FFFFF B07F00 00 1 5E MEM    E01F00 00
ex_sram_rd   00 2 001FFF 7FFFFF B07F00 00 0 00 MEM    E01F00 5E
ex_sram_off  00 2 001FFE 7FFFFF 306000 00 0 00 OPEN   000000 FF
unk_rom      00 5 001FFF 3FFFFF C01234 00 0 00 OPEN   000000 FF
unk_sram     00 5 001FFF 3FFFFF 306000 00 0 00 OPEN   000000 FF
cmd_rst      38 0 001FFF 3FFFFF 002A10 00 0 00 PERIPH 000000 00
cmd_wr       38 0 001FFF 3FFFFF 002A10 00 1 C3 PERIPH 000000 00
cmd_rd       38 0 001FFF 3FFFFF 002A10 00 0 00 PERIPH 000000 C3
msu_wr       38 0 001FFF 3FFFFF 002003 00 1 11 PERIPH 000000 00
msu_rd       38 0 001FFF 3FFFFF 002003 00 0 00 PERIPH 000000 11
obc_wr       38 0 001FFF 3FFFFF 007805 00 1 22 PERIPH 000000 00
obc_rd       38 0 001FFF 3FFFFF 007805 00 0 00 PERIPH 000000 22
r213f_wr     38 0 001FFF 3FFFFF 002100 3F 1 33 PERIPH 000000 00
r213f_rd     38 0 001FFF 3FFFFF 002100 3F 0 00 PERIPH 000000 33
msu_off      00 0 001FFF 3FFFFF 002003 00 0 00 OPEN   000000 FF
obc_off      00 0 001FFF 3FFFFF 007805 00 0 00 OPEN   000000 FF
r213f_off    00 0 001FFF 3FFFFF C00010 3F 0 00 MEM    000010 4A
cmd_off      00 0 001FFF 3FFFFF 002A10 00 0 00 PERIPH 000000 C3
bp0          00 0 001FFF 3FFFFF C000A0 00 0 00 MEM    0000A0 FA
bp1          00 0 001FFF 3FFFFF C000A1 00 0 00 MEM    0000A1 FB
bp2          00 0 001FFF 3FFFFF 002A10 00 0 00 PERIPH 000000 C3
bp3          00 0 001FFF 3FFFFF 000100 00 0 00 OPEN   000000 FF
bp4          00 0 001FFF 3FFFFF C000A2 00 0 00 MEM    0000A2 F8

// ==== filelist.f ====
rtl/snes_map_pkg.sv
rtl/pipe_reg.sv
rtl/address.sv
rtl/periph_regs.sv
rtl/access_router.sv
rtl/snes_map_top.sv
verification/snes_map_props.sv
verification/snes_map_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= snes_map_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
VECTORS := verification/snes_map_vectors.txt
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(VECTORS)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/snes_map_tb.sv ====
`default_nettype none

module snes_map_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int    CLK_PERIOD = 20;
  localparam string VEC_FILE   = "verification/snes_map_vectors.txt";

  logic CLK, rst, req_valid, req_ready, mem_valid, mem_ready, mem_rvalid;
  logic rsp_valid, rsp_ready;
  logic [7:0]              mem_rdata;
  snes_map_pkg::cfg_t      cfg;
  snes_map_pkg::snes_req_t req;
  snes_map_pkg::mem_req_t  mem_req;
  snes_map_pkg::rsp_t      rsp;

  // Vector table, one entry per access
  string                   v_name [$];
  string                   v_kind [$];   // MEM, PERIPH, OPEN or DROP
  snes_map_pkg::cfg_t      v_cfg [$];
  snes_map_pkg::snes_req_t v_req [$];
  logic [23:0]             v_addr [$];
  logic [7:0]              v_data [$];
  int                      test_err [$];
  int exp_mem [$];                        // Indices waiting on memory
  int exp_rsp [$];                        // Indices waiting on a response
  int n_vec = 0, n_done = 0, errors = 0;
  int seed = 32'h2c1b_7845;
  logic [7:0]  mem_store [int];           // Written bytes of the memory model
  logic [23:0] rd_addr;
  int rd_issued = 0, rd_served = 0, rd_wait = 0;

  initial CLK = 1'b0;
  always #(CLK_PERIOD / 2) CLK = ~CLK;

  snes_map_top #(.SNESCMD_DEPTH(256)) i_dut (
    .CLK(CLK), .rst(rst), .cfg(cfg), .req_valid(req_valid), .req_ready(req_ready), .req(req),
    .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_req(mem_req), .mem_rvalid(mem_rvalid),
    .mem_rdata(mem_rdata), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp)
  );

  task automatic load_vectors();
    int fd, n, mapper, wr;
    string line, name, kind;
    logic [7:0] feat, pa, wdata, edata;
    logic [23:0] smask, rmask, addr, eaddr;
    snes_map_pkg::cfg_t c;
    snes_map_pkg::snes_req_t r;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open vector file %s", VEC_FILE);
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line[0] != 8'h23) begin  // Skip comment lines
        n = $sscanf(line, "%s %h %d %h %h %h %h %d %h %s %h %h", name, feat, mapper,
                    smask, rmask, addr, pa, wr, wdata, kind, eaddr, edata);
        if (n == 12) begin
          c = '0;
          c.featurebits  = feat;
          c.mapper       = snes_map_pkg::mapper_e'(mapper[2:0]);
          c.saveram_mask = smask;
          c.rom_mask     = rmask;
          v_cfg.push_back(c);
          r.addr  = addr;
          r.pa    = pa;
          r.wr    = wr[0];
          r.wdata = wdata;
          v_req.push_back(r);
          v_name.push_back(name);
          v_kind.push_back(kind);
          v_addr.push_back(eaddr);
          v_data.push_back(edata);
          test_err.push_back(0);
        end
      end
    end
    $fclose(fd);
  endtask

  function automatic logic [7:0] model_byte(input logic [23:0] a);
    return mem_store.exists(int'(a)) ? mem_store[int'(a)] : a[7:0] ^ 8'h5A;
  endfunction

  function automatic snes_map_pkg::src_e src_of(input string kind);
    if (kind == "MEM") return snes_map_pkg::MEM;
    if (kind == "PERIPH") return snes_map_pkg::PERIPH;
    return snes_map_pkg::OPEN;
  endfunction

  task automatic finish_test(input int idx);
    n_done++;
    $display("%-14s %s", v_name[idx], (test_err[idx] == 0) ? "ok" : "mismatch");
  endtask

  // Expected events for an accepted request
  task automatic book(input int idx);
    if (v_kind[idx] == "MEM") exp_mem.push_back(idx);
    if (!v_req[idx].wr && v_kind[idx] != "DROP") exp_rsp.push_back(idx);
    if (v_kind[idx] == "DROP" || (v_req[idx].wr && v_kind[idx] != "MEM")) finish_test(idx);
  endtask

  task automatic send(input int idx);
    req_valid = 1'b1;
    req       = v_req[idx];
    do @(posedge CLK); while (!req_ready);
    book(idx);
    @(negedge CLK);
    req_valid = 1'b0;
  endtask

  // Pipeline empty and nothing outstanding
  task automatic wait_idle();
    while (exp_mem.size() != 0 || exp_rsp.size() != 0 || i_dut.a_valid || i_dut.b_valid
           || !i_dut.b_ready) @(negedge CLK);
  endtask

  ////////////////////////////////////////////////////
  // Memory model and checkers
  ////////////////////////////////////////////////////

  always @(posedge CLK) begin
    int idx;
    if (!rst && mem_valid && mem_ready) begin
      if (mem_req.wr) mem_store[int'(mem_req.addr)] = mem_req.wdata;
      else begin
        rd_addr = mem_req.addr;
        rd_issued++;
      end
      assert (exp_mem.size() != 0) else begin
        $display("Memory request at %h where none was expected", mem_req.addr);
        errors++;
      end
      if (exp_mem.size() != 0) begin
        idx = exp_mem.pop_front();
        assert (mem_req.addr == v_addr[idx] && mem_req.wr == v_req[idx].wr) else begin
          $display("** Error %s: mem addr expected %h actual %h", v_name[idx], v_addr[idx],
                   mem_req.addr);
          errors++;
          test_err[idx]++;
        end
        if (v_req[idx].wr) begin
          assert (mem_req.wdata == v_req[idx].wdata) else begin
            $display("** Error %s: mem wdata expected %h actual %h", v_name[idx],
                     v_req[idx].wdata, mem_req.wdata);
            errors++;
            test_err[idx]++;
          end
          finish_test(idx);
        end
      end
    end
    if (!rst && rsp_valid && rsp_ready) begin
      assert (exp_rsp.size() != 0) else begin
        $display("Response with data %h arrived with no read outstanding", rsp.data);
        errors++;
      end
      if (exp_rsp.size() != 0) begin
        idx = exp_rsp.pop_front();  // Order follows the vectors
        assert (rsp.data == v_data[idx] && rsp.src == src_of(v_kind[idx])) else begin
          $display("** Error %s: rsp expected %h/%s actual %h/%s", v_name[idx], v_data[idx],
                   v_kind[idx], rsp.data, rsp.src.name());
          errors++;
          test_err[idx]++;
        end
        finish_test(idx);
      end
    end
  end

  // Random ready levels, read data 1 to 3 cycles late
  always @(negedge CLK) begin
    int delay;
    mem_ready  = !rst && (($random(seed) & 3) != 0);
    rsp_ready  = !rst && (($random(seed) & 3) != 0);
    mem_rvalid = 1'b0;
    if (rd_wait > 0) begin
      rd_wait--;
      if (rd_wait == 0) begin
        mem_rvalid = 1'b1;
        mem_rdata  = model_byte(rd_addr);
      end
    end else if (rd_issued != rd_served) begin
      rd_served++;
      delay = 1 + ($unsigned($random(seed)) % 3);
      if (delay == 1) begin
        mem_rvalid = 1'b1;
        mem_rdata  = model_byte(rd_addr);
      end else rd_wait = delay - 1;
    end
  end

  initial begin
    rst = 1'b1;
    req_valid = 1'b0;
    req = '0;
    mem_ready = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata = 8'h00;
    rsp_ready = 1'b0;
    load_vectors();
    n_vec = v_name.size();
    cfg = (n_vec > 0) ? v_cfg[0] : '0;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    rst = 1'b0;
    for (int i = 0; i < n_vec; i++) begin
      if (v_cfg[i] != cfg) begin
        wait_idle();  // Config only moves with the pipeline empty
        cfg = v_cfg[i];
      end
      send(i);
    end
    wait_idle();
    @(negedge CLK);
    $display("Tests %0d, finished %0d, errors %0d", n_vec, n_done, errors);
    if (errors == 0 && n_vec > 0 && n_done == n_vec) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog, 200 cycles per vector
  initial begin
    wait (n_vec > 0);
    repeat (n_vec * 200) @(posedge CLK);
    $display("Timeout after %0d cycles, the DUT stopped answering", n_vec * 200);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/snes_map_props.sv ====
`default_nettype none

// Handshake rules checked on the top level ports
module snes_map_props (
  input logic                    CLK,
  input logic                    rst,
  input logic                    req_valid,
  input logic                    req_ready,
  input snes_map_pkg::snes_req_t req,
  input logic                    mem_valid,
  input logic                    mem_ready,
  input snes_map_pkg::mem_req_t  mem_req,
  input logic                    rsp_valid,
  input logic                    rsp_ready,
  input snes_map_pkg::rsp_t      rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  // Stalled channels keep valid and payload
  req_hold: assert property (@(posedge CLK) disable iff (rst)
    req_valid && !req_ready |=> req_valid && $stable(req))
    else $error("request changed while stalled");
  mem_hold: assert property (@(posedge CLK) disable iff (rst)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_req))
    else $error("memory request changed while stalled");
  rsp_hold: assert property (@(posedge CLK) disable iff (rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else $error("response changed while stalled");

  // Outputs quiet once reset has been seen
  rst_quiet: assert property (@(posedge CLK) rst |=> !mem_valid && !rsp_valid)
    else $error("valid raised during reset");

endmodule

bind snes_map_top snes_map_props i_props (
  .CLK(CLK), .rst(rst), .req_valid(req_valid), .req_ready(req_ready), .req(req),
  .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_req(mem_req),
  .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp)
);

`default_nettype wire

// ==== rtl/snes_map_top.sv ====
`default_nettype none

// Cartridge address mapper, request in, memory and responses out
module snes_map_top #(
  parameter int SNESCMD_DEPTH = 256
) (
  input  logic                    CLK,
  input  logic                    rst,
  input  snes_map_pkg::cfg_t      cfg,
  input  logic                    req_valid,
  output logic                    req_ready,
  input  snes_map_pkg::snes_req_t req,
  output logic                    mem_valid,
  input  logic                    mem_ready,
  output snes_map_pkg::mem_req_t  mem_req,
  input  logic                    mem_rvalid,
  input  logic [7:0]              mem_rdata,
  output logic                    rsp_valid,
  input  logic                    rsp_ready,
  output snes_map_pkg::rsp_t      rsp
);

  logic                    a_valid;       // Stage A output
  logic                    a_ready;
  snes_map_pkg::snes_req_t a_data;
  snes_map_pkg::decode_t   a_dec;         // Mapper result for stage A item
  logic                    b_valid;       // Stage B output
  logic                    b_ready;       // Router accept
  snes_map_pkg::decode_t   b_data;
  logic                    periph_acc;
  logic [7:0]              periph_rdata;

  //////////////////////////////////////////////////
  // Request pipeline
  //////////////////////////////////////////////////

  pipe_reg #(.T(snes_map_pkg::snes_req_t)) i_stage_a (
    .CLK       (CLK),
    .rst       (rst),
    .in_valid  (req_valid),
    .in_ready  (req_ready),
    .in_data   (req),
    .out_valid (a_valid),
    .out_ready (a_ready),
    .out_data  (a_data)
  );

  address i_address (
    .cfg (cfg),
    .req (a_data),
    .dec (a_dec)
  );

  pipe_reg #(.T(snes_map_pkg::decode_t)) i_stage_b (
    .CLK       (CLK),
    .rst       (rst),
    .in_valid  (a_valid),
    .in_ready  (a_ready),
    .in_data   (a_dec),
    .out_valid (b_valid),
    .out_ready (b_ready),
    .out_data  (b_data)
  );

  //////////////////////////////////////////////////
  // Routing and peripherals
  //////////////////////////////////////////////////

  access_router i_access_router (
    .CLK          (CLK),
    .rst          (rst),
    .in_valid     (b_valid),
    .in_ready     (b_ready),
    .dec          (b_data),
    .mem_valid    (mem_valid),
    .mem_ready    (mem_ready),
    .mem_req      (mem_req),
    .mem_rvalid   (mem_rvalid),
    .mem_rdata    (mem_rdata),
    .rsp_valid    (rsp_valid),
    .rsp_ready    (rsp_ready),
    .rsp          (rsp),
    .periph_acc   (periph_acc),
    .periph_rdata (periph_rdata)
  );

  periph_regs #(.SNESCMD_DEPTH(SNESCMD_DEPTH)) i_periph_regs (
    .CLK       (CLK),
    .rst       (rst),
    .acc_valid (periph_acc),
    .dec       (b_data),       // Same item the router is looking at
    .rdata     (periph_rdata)
  );

endmodule

`default_nettype wire

// ==== rtl/access_router.sv ====
`default_nettype none

// Sends each decoded access to memory, peripherals or open bus
module access_router (
  input  logic                   CLK,
  input  logic                   rst,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  snes_map_pkg::decode_t  dec,
  output logic                   mem_valid,
  input  logic                   mem_ready,
  output snes_map_pkg::mem_req_t mem_req,
  input  logic                   mem_rvalid,
  input  logic [7:0]             mem_rdata,
  output logic                   rsp_valid,
  input  logic                   rsp_ready,
  output snes_map_pkg::rsp_t     rsp,
  output logic                   periph_acc,
  input  logic [7:0]             periph_rdata
);

  typedef enum logic [1:0] {
    IDLE,      // Waiting for an access
    MEM_REQ,   // Presenting the memory request
    MEM_WAIT,  // Read issued, waiting for data
    RSP        // Holding the read response
  } state_e;

  state_e                 state;
  state_e                 state_d;
  logic                   accept;
  logic                   periph_sel;  // Any enabled window
  snes_map_pkg::mem_req_t mem_q;
  snes_map_pkg::rsp_t     rsp_q;

  assign in_ready   = (state == IDLE);
  assign accept     = in_valid & in_ready;
  assign periph_sel = dec.msu_enable | dec.r213f_enable | dec.snescmd_enable | dec.obc1_enable;
  assign periph_acc = accept & periph_sel;  // Writes land at this edge

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state;
    case (state)
      IDLE: begin
        if (in_valid) begin
          if (periph_sel) begin
            state_d = dec.req.wr ? IDLE : RSP;      // Peripherals beat memory
          end else if (dec.req.wr) begin
            state_d = dec.is_writable ? MEM_REQ : IDLE;  // ROM writes dropped
          end else begin
            state_d = dec.rom_hit ? MEM_REQ : RSP;  // Else open bus
          end
        end
      end
      MEM_REQ: begin
        if (mem_ready) begin
          state_d = mem_q.wr ? IDLE : MEM_WAIT;
        end
      end
      MEM_WAIT: begin
        if (mem_rvalid) begin
          state_d = RSP;
        end
      end
      RSP: begin
        if (rsp_ready) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_d;
    end
  end

  // Payload capture
  always_ff @(posedge CLK) begin
    if (accept) begin
      mem_q <= '{addr: dec.rom_addr, wr: dec.req.wr, wdata: dec.req.wdata};
      if (periph_sel) begin
        rsp_q <= '{data: periph_rdata, src: snes_map_pkg::PERIPH};
      end else begin
        rsp_q <= '{data: snes_map_pkg::OPEN_BUS, src: snes_map_pkg::OPEN};
      end
    end else if (state == MEM_WAIT && mem_rvalid) begin
      rsp_q <= '{data: mem_rdata, src: snes_map_pkg::MEM};  // Memory read returns
    end
  end

  assign mem_valid = (state == MEM_REQ);
  assign mem_req   = mem_q;
  assign rsp_valid = (state == RSP);
  assign rsp       = rsp_q;

endmodule

`default_nettype wire

// ==== rtl/periph_regs.sv ====
`default_nettype none

// Register file behind the feature windows
module periph_regs #(
  parameter int SNESCMD_DEPTH = 256
) (
  input  logic                  CLK,
  input  logic                  rst,
  input  logic                  acc_valid,  // One cycle access strobe
  input  snes_map_pkg::decode_t dec,
  output logic [7:0]            rdata
);

  localparam int IDX_W = $clog2(SNESCMD_DEPTH);

  logic [7:0]       cmd_ram [SNESCMD_DEPTH];  // snescmd area
  logic [7:0]       msu_regs [8];
  logic [7:0]       obc1_regs [8];
  logic [7:0]       r213f_q;
  logic [IDX_W-1:0] cmd_idx;                  // Wraps to the depth
  logic [2:0]       reg_idx;
  logic             wr_en;

  assign cmd_idx = dec.req.addr[IDX_W-1:0];
  assign reg_idx = dec.req.addr[2:0];
  assign wr_en   = acc_valid & dec.req.wr;

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 0; i < SNESCMD_DEPTH; i++) begin
        cmd_ram[i] <= 8'h00;
      end
      for (int j = 0; j < 8; j++) begin
        msu_regs[j]  <= 8'h00;
        obc1_regs[j] <= 8'h00;
      end
      r213f_q <= 8'h00;
    end else if (wr_en) begin
      // Same priority as the read mux
      if (dec.snescmd_enable) begin
        cmd_ram[cmd_idx] <= dec.req.wdata;
      end else if (dec.msu_enable) begin
        msu_regs[reg_idx] <= dec.req.wdata;
      end else if (dec.obc1_enable) begin
        obc1_regs[reg_idx] <= dec.req.wdata;
      end else if (dec.r213f_enable) begin
        r213f_q <= dec.req.wdata;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////

  always_comb begin
    if (dec.snescmd_enable) begin
      rdata = cmd_ram[cmd_idx];
    end else if (dec.msu_enable) begin
      rdata = msu_regs[reg_idx];
    end else if (dec.obc1_enable) begin
      rdata = obc1_regs[reg_idx];
    end else if (dec.r213f_enable) begin
      rdata = r213f_q;
    end else begin
      rdata = 8'h00;  // No window selected
    end
  end

endmodule

`default_nettype wire

// ==== rtl/address.sv ====
`default_nettype none

// Mapper decode, purely combinational
module address (
  input  snes_map_pkg::cfg_t      cfg,
  input  snes_map_pkg::snes_req_t req,
  output snes_map_pkg::decode_t   dec
);

  logic [23:0] a;           // Shorthand for the SNES address
  logic        map_known;   // Mapper code is one we support
  logic        sram_hit;    // Save RAM window before mask gating
  logic        is_rom;
  logic        is_saveram;
  logic [23:0] mem_addr;

  assign a         = req.addr;
  assign map_known = cfg.mapper inside {snes_map_pkg::HIROM, snes_map_pkg::LOROM,
                                        snes_map_pkg::EXHIROM};

  // Upper half of banks 00 to 3F, or anything in 40 to 7F
  assign is_rom = map_known & (a[22] | (!a[22] & a[15]));

  //////////////////////////////////////////////////
  // Save RAM window per mapper
  //////////////////////////////////////////////////

  always_comb begin
    case (cfg.mapper)
      snes_map_pkg::HIROM, snes_map_pkg::EXHIROM:
        sram_hit = !a[22] & (&a[21:20]) & (&a[14:13]) & !a[15];  // Banks 30 to 3F at 6000 to 7FFF
      snes_map_pkg::LOROM:
        // Banks 70 to 7D, low half only on large ROMs
        sram_hit = (&a[22:20]) & (a[19:16] < 4'hE) & (!a[15] | !cfg.rom_mask[21]);
      default:
        sram_hit = 1'b0;
    endcase
  end

  assign is_saveram = cfg.saveram_mask[0] & sram_hit;

  //////////////////////////////////////////////////
  // Memory address per mapper
  //////////////////////////////////////////////////

  always_comb begin
    case (cfg.mapper)
      snes_map_pkg::HIROM:
        mem_addr = is_saveram
          ? snes_map_pkg::SAVERAM_BASE + ({6'd0, a[20:16], a[12:0]} & cfg.saveram_mask)
          : ({1'b0, a[22:0]} & cfg.rom_mask);
      snes_map_pkg::LOROM:
        mem_addr = is_saveram
          ? snes_map_pkg::SAVERAM_BASE + ({4'd0, a[20:16], a[14:0]} & cfg.saveram_mask)
          : ({2'b00, a[22:16], a[14:0]} & cfg.rom_mask);  // Drop A15
      snes_map_pkg::EXHIROM:
        mem_addr = is_saveram
          ? snes_map_pkg::SAVERAM_BASE + ({6'd0, a[20:16], a[12:0]} & cfg.saveram_mask)
          : ({1'b0, !a[23], a[21:0]} & cfg.rom_mask);  // Banks 00 to 7F on top
      default:
        mem_addr = 24'd0;
    endcase
  end

  always_comb begin
    dec             = '0;
    dec.req         = req;
    dec.rom_addr    = mem_addr;
    dec.is_rom      = is_rom;
    dec.is_saveram  = is_saveram;
    dec.is_writable = is_saveram;           // Only save RAM takes writes
    dec.rom_hit     = is_rom | is_saveram;
    // Feature windows
    dec.msu_enable   = cfg.featurebits[snes_map_pkg::FEAT_MSU1] & !a[22]
                       & ((a[15:0] & 16'hFFF8) == 16'h2000);
    dec.r213f_enable = cfg.featurebits[snes_map_pkg::FEAT_213F] & (req.pa == 8'h3F);
    dec.obc1_enable  = cfg.featurebits[snes_map_pkg::FEAT_OBC1] & !a[22]
                       & (a[15:11] == 5'b01111);
    dec.snescmd_enable = ({a[22], a[15:8]} == 9'b0_0010_1010);  // Always on
  end

endmodule

`default_nettype wire

// ==== rtl/pipe_reg.sv ====
`default_nettype none

// One entry register slice, full throughput when drained every cycle
module pipe_reg #(
  parameter type T = logic [7:0]
) (
  input  logic CLK,
  input  logic rst,
  input  logic in_valid,
  output logic in_ready,
  input  T     in_data,
  output logic out_valid,
  input  logic out_ready,
  output T     out_data
);

  logic full;    // Slot occupied
  T     data_q;  // Held payload

  // Free slot, or the held item leaves this cycle
  assign in_ready = !full || out_ready;

  always_ff @(posedge CLK) begin
    if (rst) begin
      full <= 1'b0;
    end else if (in_valid && in_ready) begin
      full <= 1'b1;  // Refill, possibly same cycle as drain
    end else if (out_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

  assign out_valid = full;
  assign out_data  = data_q;

endmodule

`default_nettype wire

// ==== rtl/snes_map_pkg.sv ====
`default_nettype none

package snes_map_pkg;

  //////////////////////////////////////////////////
  // Mapper and feature codes
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    HIROM   = 3'd0,
    LOROM   = 3'd1,
    EXHIROM = 3'd2
  } mapper_e;  // Codes 3 to 7 map nothing

  // Bit positions in featurebits
  localparam int FEAT_MSU1 = 3;
  localparam int FEAT_213F = 4;
  localparam int FEAT_OBC1 = 5;

  localparam logic [23:0] SAVERAM_BASE = 24'hE0_0000;  // Save RAM start in memory
  localparam logic [7:0]  OPEN_BUS     = 8'hFF;        // Unmapped read value

  typedef enum logic [1:0] {
    MEM    = 2'd0,  // Byte from external memory
    PERIPH = 2'd1,  // Byte from register file
    OPEN   = 2'd2   // Nobody answered
  } src_e;

  //////////////////////////////////////////////////
  // Payload structs
  //////////////////////////////////////////////////

  // Quasi static, only changes with the pipeline empty
  typedef struct packed {
    logic [7:0]  featurebits;
    mapper_e     mapper;
    logic [23:0] saveram_mask;  // Bit 0 also enables save RAM
    logic [23:0] rom_mask;
    logic [12:0] pad;           // Byte alignment
  } cfg_t;

  typedef struct packed {
    logic [23:0] addr;   // A bus address
    logic [7:0]  pa;     // B bus peripheral address
    logic        wr;
    logic [7:0]  wdata;
  } snes_req_t;

  // Request plus everything the mapper worked out for it
  typedef struct packed {
    snes_req_t   req;
    logic [23:0] rom_addr;  // Masked memory address
    logic        rom_hit;
    logic        is_rom;
    logic        is_saveram;
    logic        is_writable;
    logic        msu_enable;
    logic        r213f_enable;
    logic        snescmd_enable;
    logic        obc1_enable;
  } decode_t;

  typedef struct packed {
    logic [23:0] addr;
    logic        wr;
    logic [7:0]  wdata;
  } mem_req_t;

  typedef struct packed {
    logic [7:0] data;
    src_e       src;
  } rsp_t;

endpackage

`default_nettype wire
